// File: rtl/ls_pkg.sv
`default_nettype none

package ls_pkg;

    // datapath widths
    localparam int xlen        = 32;
    localparam int rob_tag_len = 5;

    // memory opcode
    typedef enum logic [1:0] {
        ls_load  = 2'd0, // sign-extending load
        ls_loadu = 2'd1, // zero-extending load
        ls_store = 2'd2
    } ls_func_e;

    // access size
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } ls_size_e;

    // load/store unit FSM
    typedef enum logic [1:0] {
        lsu_idle = 2'd0, // waiting for queue head
        lsu_mem  = 2'd1, // request held until hit
        lsu_wb   = 2'd2  // result waiting for writeback port
    } lsu_state_e;

endpackage

`default_nettype wire

// File: rtl/ls_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module ls_issue_queue import ls_pkg::*; #(
    parameter int xlen        = ls_pkg::xlen,
    parameter int tag_len     = rob_tag_len,
    parameter int queue_depth = 4
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               in_req,
    input  ls_func_e           in_func,
    input  ls_size_e           in_size,
    input  logic [xlen-1:0]    in_base,
    input  logic [xlen-1:0]    in_imm,
    input  logic [xlen-1:0]    in_store_data,
    input  logic [tag_len-1:0] in_tag,
    output logic               in_ack,
    input  logic               q_pop,
    output logic               q_valid,
    output ls_func_e           q_func,
    output ls_size_e           q_size,
    output logic [xlen-1:0]    q_base,
    output logic [xlen-1:0]    q_imm,
    output logic [xlen-1:0]    q_store_data,
    output logic [tag_len-1:0] q_tag
);

    localparam int ptr_w = $clog2(queue_depth);
    localparam int cnt_w = $clog2(queue_depth + 1);

    // entry storage, one array per field
    ls_func_e           func_q  [queue_depth];
    ls_size_e           size_q  [queue_depth];
    logic [xlen-1:0]    base_q  [queue_depth];
    logic [xlen-1:0]    imm_q   [queue_depth];
    logic [xlen-1:0]    sdata_q [queue_depth];
    logic [tag_len-1:0] tag_q   [queue_depth];

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;

    assign full = (count == cnt_w'(queue_depth));
    assign push = in_req && !in_ack && !full; // one entry per req phase

    // receiving side of four-phase handshake
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            in_ack <= 1'b0;
        end else if (push) begin
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            in_ack <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            func_q[tail]  <= in_func;
            size_q[tail]  <= in_size;
            base_q[tail]  <= in_base;
            imm_q[tail]   <= in_imm;
            sdata_q[tail] <= in_store_data;
            tag_q[tail]   <= in_tag;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push)
                tail <= tail + 1'b1;
            if (q_pop)
                head <= head + 1'b1;
            case ({push, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign q_valid      = (count != '0);
    assign q_func       = func_q[head];
    assign q_size       = size_q[head];
    assign q_base       = base_q[head];
    assign q_imm        = imm_q[head];
    assign q_store_data = sdata_q[head];
    assign q_tag        = tag_q[head];

    // unit must only take a valid head
    a_no_pop_empty: assert property (@(posedge clock) disable iff (!arst_n)
        q_pop |-> q_valid);

    a_count_bound: assert property (@(posedge clock) disable iff (!arst_n)
        count <= cnt_w'(queue_depth));

endmodule

`default_nettype wire

// File: rtl/ls_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ls_unit import ls_pkg::*; #(
    parameter int xlen    = ls_pkg::xlen,
    parameter int tag_len = rob_tag_len
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               q_valid,
    input  ls_func_e           q_func,
    input  ls_size_e           q_size,
    input  logic [xlen-1:0]    q_base,
    input  logic [xlen-1:0]    q_imm,
    input  logic [xlen-1:0]    q_store_data,
    input  logic [tag_len-1:0] q_tag,
    output logic               q_pop,
    output logic               mem_read,
    output logic               mem_write,
    output logic [xlen-1:0]    mem_addr,
    output ls_size_e           mem_size,
    output logic [xlen-1:0]    mem_wdata,
    input  logic               mem_hit,
    input  logic [xlen-1:0]    mem_rdata,
    input  logic               port_busy,
    output logic               res_valid,
    output logic [tag_len-1:0] res_tag,
    output logic [xlen-1:0]    res_data,
    output logic               res_store
);

    lsu_state_e state;

    // latched instruction
    ls_func_e           func_q;
    ls_size_e           size_q;
    logic [xlen-1:0]    addr_q;
    logic [xlen-1:0]    wdata_q;
    logic [tag_len-1:0] tag_q;
    logic [xlen-1:0]    res_data_q;

    logic [xlen-1:0] agen_addr;
    logic [xlen-1:0] st_lane;
    logic [xlen-1:0] st_shifted;
    logic [xlen-1:0] ld_lane;
    logic [xlen-1:0] ld_ext;
    logic            sign_bit;

    assign agen_addr = q_base + q_imm;

    // move store data up into its byte lane
    always_comb begin
        case (q_size)
            size_byte: st_lane = {{(xlen-8){1'b0}}, q_store_data[7:0]};
            size_half: st_lane = {{(xlen-16){1'b0}}, q_store_data[15:0]};
            default:   st_lane = q_store_data;
        endcase
        st_shifted = st_lane << {agen_addr[1:0], 3'b000};
    end

    // pull the addressed lane down, then extend
    always_comb begin
        ld_lane  = mem_rdata >> {addr_q[1:0], 3'b000};
        sign_bit = 1'b0;
        case (size_q)
            size_byte: begin
                sign_bit = (func_q == ls_load) && ld_lane[7];
                ld_ext   = {{(xlen-8){sign_bit}}, ld_lane[7:0]};
            end
            size_half: begin
                sign_bit = (func_q == ls_load) && ld_lane[15];
                ld_ext   = {{(xlen-16){sign_bit}}, ld_lane[15:0]};
            end
            default:   ld_ext = ld_lane;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= lsu_idle;
        end else begin
            case (state)
                lsu_idle: if (q_valid)    state <= lsu_mem;
                lsu_mem:  if (mem_hit)    state <= lsu_wb;
                lsu_wb:   if (!port_busy) state <= lsu_idle;
                default:                  state <= lsu_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (q_pop) begin
            func_q  <= q_func;
            size_q  <= q_size;
            addr_q  <= agen_addr;
            wdata_q <= st_shifted;
            tag_q   <= q_tag;
        end
        if (state == lsu_mem && mem_hit)
            res_data_q <= (func_q == ls_store) ? '0 : ld_ext; // stores report zero
    end

    assign q_pop = (state == lsu_idle) && q_valid;

    // request held for the whole lsu_mem state
    assign mem_read  = (state == lsu_mem) && (func_q != ls_store);
    assign mem_write = (state == lsu_mem) && (func_q == ls_store);
    assign mem_addr  = addr_q;
    assign mem_size  = size_q;
    assign mem_wdata = wdata_q;

    assign res_valid = (state == lsu_wb) && !port_busy;
    assign res_tag   = tag_q;
    assign res_data  = res_data_q;
    assign res_store = (func_q == ls_store);

    a_rw_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
        !(mem_read && mem_write));

    // fields frozen until the memory answers
    a_req_stable: assert property (@(posedge clock) disable iff (!arst_n)
        (mem_read || mem_write) && !mem_hit |=>
            $stable(mem_read) && $stable(mem_write) && $stable(mem_addr) &&
            $stable(mem_size) && $stable(mem_wdata));

    a_aligned: assert property (@(posedge clock) disable iff (!arst_n)
        (mem_read || mem_write) |->
            !(mem_size == size_half && mem_addr[0]) &&
            !(mem_size == size_word && mem_addr[1:0] != 2'b00));

endmodule

`default_nettype wire

// File: rtl/ls_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module ls_data_mem import ls_pkg::*; #(
    parameter int xlen      = ls_pkg::xlen,
    parameter int mem_words = 256,
    parameter int mem_wait  = 2
) (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            mem_read,
    input  logic            mem_write,
    input  logic [xlen-1:0] mem_addr,
    input  ls_size_e        mem_size,
    input  logic [xlen-1:0] mem_wdata,
    output logic            mem_hit,
    output logic [xlen-1:0] mem_rdata
);

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = $clog2(mem_wait + 1);
    localparam int lanes = xlen / 8;

    logic [xlen-1:0] mem_q [mem_words] = '{default: '0}; // starts cleared

    logic [idx_w-1:0] word_idx;
    logic [lanes-1:0] byte_en;
    logic [cnt_w-1:0] wait_cnt;
    logic             req;
    logic             done;

    assign req      = mem_read || mem_write;
    assign word_idx = idx_w'((mem_addr >> 2) % mem_words);
    assign done     = req && !mem_hit && (wait_cnt == cnt_w'(mem_wait - 1));

    // lanes touched by a write
    always_comb begin
        case (mem_size)
            size_byte: byte_en = lanes'(1) << mem_addr[1:0];
            size_half: byte_en = lanes'(3) << mem_addr[1:0];
            default:   byte_en = '1;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
            mem_hit  <= 1'b0;
        end else begin
            mem_hit <= done;
            if (done)
                wait_cnt <= '0;
            else if (req && !mem_hit)
                wait_cnt <= wait_cnt + 1'b1; // still waiting
        end
    end

    always_ff @(posedge clock) begin
        if (done) begin
            if (mem_write) begin
                for (int b = 0; b < lanes; b++) begin
                    if (byte_en[b])
                        mem_q[word_idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                end
            end else begin
                mem_rdata <= mem_q[word_idx]; // whole word, unit picks the lane
            end
        end
    end

    // requester must drop right after a hit
    a_gap_after_hit: assert property (@(posedge clock) disable iff (!arst_n)
        mem_hit |=> !(mem_read || mem_write));

endmodule

`default_nettype wire

// File: rtl/ls_wb_port.sv
`timescale 1ns/1ps
`default_nettype none

module ls_wb_port import ls_pkg::*; #(
    parameter int xlen    = ls_pkg::xlen,
    parameter int tag_len = rob_tag_len
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               res_valid,
    input  logic [tag_len-1:0] res_tag,
    input  logic [xlen-1:0]    res_data,
    input  logic               res_store,
    output logic               port_busy,
    output logic               wb_req,
    output logic [tag_len-1:0] wb_tag,
    output logic [xlen-1:0]    wb_data,
    output logic               wb_store,
    input  logic               wb_ack
);

    typedef enum logic [1:0] {
        wb_idle    = 2'd0,
        wb_send    = 2'd1, // req high, waiting for ack
        wb_release = 2'd2  // req low, waiting for ack to fall
    } wb_phase_e;

    wb_phase_e phase;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            phase <= wb_idle;
        end else begin
            case (phase)
                wb_idle:    if (res_valid) phase <= wb_send;
                wb_send:    if (wb_ack)    phase <= wb_release;
                wb_release: if (!wb_ack)   phase <= wb_idle;
                default:                   phase <= wb_idle;
            endcase
        end
    end

    // holding register
    always_ff @(posedge clock) begin
        if (phase == wb_idle && res_valid) begin
            wb_tag   <= res_tag;
            wb_data  <= res_data;
            wb_store <= res_store;
        end
    end

    assign wb_req    = (phase == wb_send);
    assign port_busy = (phase != wb_idle); // free only once ack is low again

    a_no_result_when_busy: assert property (@(posedge clock) disable iff (!arst_n)
        res_valid |-> !port_busy);

endmodule

`default_nettype wire

// File: rtl/ls_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module ls_subsystem import ls_pkg::*; #(
    parameter int xlen        = ls_pkg::xlen,
    parameter int tag_len     = rob_tag_len,
    parameter int queue_depth = 4,
    parameter int mem_words   = 256,
    parameter int mem_wait    = 2
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               in_req,
    input  ls_func_e           in_func,
    input  ls_size_e           in_size,
    input  logic [xlen-1:0]    in_base,
    input  logic [xlen-1:0]    in_imm,
    input  logic [xlen-1:0]    in_store_data,
    input  logic [tag_len-1:0] in_tag,
    output logic               in_ack,
    output logic               wb_req,
    output logic [tag_len-1:0] wb_tag,
    output logic [xlen-1:0]    wb_data,
    output logic               wb_store,
    input  logic               wb_ack
);

    // queue head
    logic               q_valid;
    logic               q_pop;
    ls_func_e           q_func;
    ls_size_e           q_size;
    logic [xlen-1:0]    q_base;
    logic [xlen-1:0]    q_imm;
    logic [xlen-1:0]    q_store_data;
    logic [tag_len-1:0] q_tag;

    // memory side
    logic            mem_read;
    logic            mem_write;
    logic [xlen-1:0] mem_addr;
    ls_size_e        mem_size;
    logic [xlen-1:0] mem_wdata;
    logic            mem_hit;
    logic [xlen-1:0] mem_rdata;

    // result to writeback port
    logic               res_valid;
    logic [tag_len-1:0] res_tag;
    logic [xlen-1:0]    res_data;
    logic               res_store;
    logic               port_busy;

    ls_issue_queue #(
        .xlen(xlen), .tag_len(tag_len), .queue_depth(queue_depth)
    ) ls_issue_queue_i (
        .clock(clock), .arst_n(arst_n),
        .in_req(in_req), .in_func(in_func), .in_size(in_size),
        .in_base(in_base), .in_imm(in_imm), .in_store_data(in_store_data),
        .in_tag(in_tag), .in_ack(in_ack),
        .q_pop(q_pop), .q_valid(q_valid), .q_func(q_func), .q_size(q_size),
        .q_base(q_base), .q_imm(q_imm), .q_store_data(q_store_data), .q_tag(q_tag)
    );

    ls_unit #(
        .xlen(xlen), .tag_len(tag_len)
    ) ls_unit_i (
        .clock(clock), .arst_n(arst_n),
        .q_valid(q_valid), .q_func(q_func), .q_size(q_size), .q_base(q_base),
        .q_imm(q_imm), .q_store_data(q_store_data), .q_tag(q_tag), .q_pop(q_pop),
        .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_size(mem_size), .mem_wdata(mem_wdata),
        .mem_hit(mem_hit), .mem_rdata(mem_rdata),
        .port_busy(port_busy), .res_valid(res_valid), .res_tag(res_tag),
        .res_data(res_data), .res_store(res_store)
    );

    ls_data_mem #(
        .xlen(xlen), .mem_words(mem_words), .mem_wait(mem_wait)
    ) ls_data_mem_i (
        .clock(clock), .arst_n(arst_n),
        .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_size(mem_size), .mem_wdata(mem_wdata),
        .mem_hit(mem_hit), .mem_rdata(mem_rdata)
    );

    ls_wb_port #(
        .xlen(xlen), .tag_len(tag_len)
    ) ls_wb_port_i (
        .clock(clock), .arst_n(arst_n),
        .res_valid(res_valid), .res_tag(res_tag), .res_data(res_data),
        .res_store(res_store), .port_busy(port_busy),
        .wb_req(wb_req), .wb_tag(wb_tag), .wb_data(wb_data),
        .wb_store(wb_store), .wb_ack(wb_ack)
    );

endmodule

`default_nettype wire

// File: testbench/ls_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ls_subsystem_tb import ls_pkg::*;;

    localparam int depth      = 4;
    localparam int wait_limit = 1000; // cycles per wait loop
    localparam int ref_bytes  = 1024; // 256 words

    logic                   clock = 1'b0;
    logic                   arst_n;
    logic                   in_req;
    ls_func_e               in_func;
    ls_size_e               in_size;
    logic [xlen-1:0]        in_base;
    logic [xlen-1:0]        in_imm;
    logic [xlen-1:0]        in_store_data;
    logic [rob_tag_len-1:0] in_tag;
    logic                   in_ack;
    logic                   wb_req;
    logic [rob_tag_len-1:0] wb_tag;
    logic [xlen-1:0]        wb_data;
    logic                   wb_store;
    logic                   wb_ack;

    logic [7:0]             ref_mem [0:ref_bytes-1];
    logic [rob_tag_len-1:0] exp_tag [$];
    logic [xlen-1:0]        exp_data [$];
    bit                     exp_store [$];

    int tag_errors   = 0;
    int data_errors  = 0;
    int flag_errors  = 0;
    int other_errors = 0;

    ls_subsystem #(
        .xlen(xlen), .tag_len(rob_tag_len), .queue_depth(depth),
        .mem_words(ref_bytes / 4), .mem_wait(2)
    ) ls_subsystem_i (
        .clock(clock), .arst_n(arst_n),
        .in_req(in_req), .in_func(in_func), .in_size(in_size), .in_base(in_base),
        .in_imm(in_imm), .in_store_data(in_store_data), .in_tag(in_tag),
        .in_ack(in_ack),
        .wb_req(wb_req), .wb_tag(wb_tag), .wb_data(wb_data), .wb_store(wb_store),
        .wb_ack(wb_ack)
    );

    always #4 clock = ~clock;

    task automatic step();
        @(posedge clock);
        #1; // drive and sample just after the edge
    endtask

    task automatic finish_run();
        int total;
        total = tag_errors + data_errors + flag_errors + other_errors;
        $display("summary: %0d tag, %0d data, %0d flag, %0d other errors, %0d in total",
                 tag_errors, data_errors, flag_errors, other_errors, total);
        if (total == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    endtask

    task automatic abort_run(string why);
        other_errors++;
        $display("timeout at %0t ns: %s", $time, why);
        finish_run();
    endtask

    task automatic check_tag(string name, logic [rob_tag_len-1:0] exp,
                             logic [rob_tag_len-1:0] act);
        if (act !== exp) begin
            tag_errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_data(string name, logic [xlen-1:0] exp, logic [xlen-1:0] act);
        if (act !== exp) begin
            data_errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, bit exp, logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    function automatic int size_bytes(ls_size_e size);
        case (size)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // little endian lanes with the sign from the top byte read
    function automatic logic [xlen-1:0] load_value(int addr, ls_size_e size, bit signed_ld);
        logic [xlen-1:0] v;
        int              n;
        n = size_bytes(size);
        v = '0;
        for (int i = 0; i < n; i++)
            v[8*i +: 8] = ref_mem[addr + i];
        if (signed_ld && ref_mem[addr + n - 1][7]) begin
            for (int i = n; i < 4; i++)
                v[8*i +: 8] = 8'hff;
        end
        return v;
    endfunction

    // models the access in program order and runs the input handshake
    task automatic dispatch(ls_func_e func, ls_size_e size, int addr, logic [xlen-1:0] imm,
                            logic [xlen-1:0] sdata, logic [rob_tag_len-1:0] tag);
        int cycles;
        exp_tag.push_back(tag);
        exp_store.push_back(func == ls_store);
        if (func == ls_store) begin
            exp_data.push_back('0);
            for (int i = 0; i < size_bytes(size); i++)
                ref_mem[addr + i] = sdata[8*i +: 8];
        end else begin
            exp_data.push_back(load_value(addr, size, func == ls_load));
        end
        in_func       = func;
        in_size       = size;
        in_base       = xlen'(addr) - imm; // base plus imm lands on addr
        in_imm        = imm;
        in_store_data = sdata;
        in_tag        = tag;
        in_req        = 1'b1;
        cycles = 0;
        while (!in_ack && cycles < wait_limit) begin
            step();
            cycles++;
        end
        if (!in_ack)
            abort_run("in_ack never rose for a dispatched instruction");
        in_req = 1'b0;
        cycles = 0;
        while (in_ack && cycles < wait_limit) begin
            step();
            cycles++;
        end
        if (in_ack)
            abort_run("in_ack stayed high after in_req fell");
    endtask

    task automatic collect(int count, int ack_delay);
        int cycles;
        int n;
        for (n = 0; n < count; n++) begin
            cycles = 0;
            while (!wb_req && cycles < wait_limit) begin
                step();
                cycles++;
            end
            if (!wb_req)
                abort_run("wb_req never rose for an expected completion");
            if (exp_tag.size() == 0) begin
                other_errors++;
                $display("a completion arrived with no instruction outstanding");
            end else begin
                check_tag("wb_tag", exp_tag.pop_front(), wb_tag);
                check_data("wb_data", exp_data.pop_front(), wb_data);
                check_flag("wb_store", exp_store.pop_front(), wb_store);
            end
            repeat (ack_delay) step();
            wb_ack = 1'b1;
            cycles = 0;
            while (wb_req && cycles < wait_limit) begin
                step();
                cycles++;
            end
            if (wb_req)
                abort_run("wb_req stayed high after wb_ack rose");
            wb_ack = 1'b0;
        end
    endtask

    task automatic test_reset_idle();
        repeat (10) begin
            check_flag("in_ack", 1'b0, in_ack);
            check_flag("wb_req", 1'b0, wb_req);
            step();
        end
    endtask

    task automatic test_word_store_load();
        fork
            begin
                dispatch(ls_store, size_word, 'h20, 32'd12, 32'hdeadbeef, 5'd3);
                dispatch(ls_load, size_word, 'h20, 32'd0, 32'h0, 5'd4);
            end
            collect(2, 0);
        join
    endtask

    // lanes of 0x40 written one by one and read back every way
    task automatic test_lane_access();
        fork
            begin
                dispatch(ls_store, size_word, 'h40, 32'd4, 32'h112233c4, 5'd5);
                dispatch(ls_store, size_byte, 'h41, 32'd1, 32'hffffff85, 5'd6);
                dispatch(ls_store, size_half, 'h42, 32'hfffffff0, 32'h0000a7c6, 5'd7);
                dispatch(ls_load, size_word, 'h40, 32'd0, 32'h0, 5'd8);
                dispatch(ls_load, size_byte, 'h40, 32'd0, 32'h0, 5'd9);
                dispatch(ls_loadu, size_byte, 'h40, 32'd0, 32'h0, 5'd10);
                dispatch(ls_load, size_byte, 'h41, 32'd0, 32'h0, 5'd11);
                dispatch(ls_loadu, size_byte, 'h41, 32'd0, 32'h0, 5'd12);
                dispatch(ls_load, size_byte, 'h42, 32'd2, 32'h0, 5'd13);
                dispatch(ls_loadu, size_byte, 'h42, 32'd0, 32'h0, 5'd14);
                dispatch(ls_load, size_byte, 'h43, 32'd3, 32'h0, 5'd15);
                dispatch(ls_loadu, size_byte, 'h43, 32'd0, 32'h0, 5'd16);
                dispatch(ls_load, size_half, 'h40, 32'd0, 32'h0, 5'd17);
                dispatch(ls_loadu, size_half, 'h40, 32'd0, 32'h0, 5'd18);
                dispatch(ls_load, size_half, 'h42, 32'd0, 32'h0, 5'd19);
                dispatch(ls_loadu, size_half, 'h42, 32'd8, 32'h0, 5'd20);
            end
            collect(16, 0);
        join
    endtask

    task automatic test_back_pressure();
        fork
            begin
                for (int i = 0; i < depth + 4; i++) begin
                    if (i % 2 == 0)
                        dispatch(ls_store, size_word, 'h100 + 4 * i, 32'd0,
                                 32'h5a5a0000 + i, rob_tag_len'(16 + i));
                    else
                        dispatch(ls_load, size_word, 'h100 + 4 * (i - 1), 32'd0,
                                 32'h0, rob_tag_len'(16 + i));
                end
            end
            collect(depth + 4, 40); // slow consumer stalls the unit
        join
    endtask

    task automatic test_random_mix();
        ls_func_e func;
        ls_size_e size;
        int       addr;
        fork
            begin
                repeat (60) begin
                    func = ls_func_e'($urandom % 3);
                    size = ls_size_e'($urandom % 3);
                    addr = $urandom % ref_bytes;
                    addr = addr - (addr % size_bytes(size)); // aligned
                    dispatch(func, size, addr, $urandom % 256, $urandom,
                             rob_tag_len'($urandom));
                end
            end
            collect(60, 0);
        join
    endtask

    initial begin
        void'($urandom(32'hfc50735b));
        for (int i = 0; i < ref_bytes; i++)
            ref_mem[i] = 8'h00;
        arst_n        = 1'b0;
        in_req        = 1'b0;
        in_func       = ls_load;
        in_size       = size_word;
        in_base       = '0;
        in_imm        = '0;
        in_store_data = '0;
        in_tag        = '0;
        wb_ack        = 1'b0;
        repeat (4) @(posedge clock);
        #1 arst_n = 1'b1;
        test_reset_idle();
        test_word_store_load();
        test_lane_access();
        test_back_pressure();
        test_random_mix();
        if (exp_tag.size() != 0) begin
            other_errors++;
            $display("%0d instructions never completed", exp_tag.size());
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: ls_sys.f
rtl/ls_pkg.sv
rtl/ls_issue_queue.sv
rtl/ls_unit.sv
rtl/ls_data_mem.sv
rtl/ls_wb_port.sv
rtl/ls_subsystem.sv
testbench/ls_subsystem_tb.sv

// File: Bender.yml
package:
  name: ls_sys

sources:
  - rtl/ls_pkg.sv
  - rtl/ls_issue_queue.sv
  - rtl/ls_unit.sv
  - rtl/ls_data_mem.sv
  - rtl/ls_wb_port.sv
  - rtl/ls_subsystem.sv
  - target: test
    files:
      - testbench/ls_subsystem_tb.sv
